// File: hw/pipePkg.sv
`default_nettype none

package pipePkg;

	// cause codes as seen by the exception record.
	typedef enum logic [4:0] {
		excAdEL = 5'd4,
		excAdES = 5'd5,
		excRI   = 5'd10,
		excOv   = 5'd12,
		excNone = 5'd15
	} excCode_t;

	typedef enum logic [1:0] {
		sizeWord  = 2'd0,
		sizeHalf  = 2'd1,
		sizeHalfU = 2'd2
	} memSize_t;

	// primary opcodes.
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opLh      = 6'h21;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opLhu     = 6'h25;
	localparam logic [5:0] opSh      = 6'h29;
	localparam logic [5:0] opSw      = 6'h2b;

	// function field under opSpecial.
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;

	// one instruction word, read either as register or immediate format.
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
	} instrWord_t;

endpackage

`default_nettype wire

// File: hw/fetchStage.sv
`default_nettype none

module fetchStage #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_3000,
	parameter logic [31:0] EXC_VECTOR   = 32'h8000_0180
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        fetch,
	input  logic        flush,
	input  logic [31:0] instr,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic [31:0] pc,
	output logic        idValid,
	output logic [31:0] idPc,
	output logic [31:0] idInstr,
	output logic [31:0] idRs,
	output logic [31:0] idRt
);

	// program counter.
	// a flush wins over a fetch in the same cycle, so the vector is not stepped.
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= RESET_VECTOR;
		end else if (flush) begin
			pc <= EXC_VECTOR;
		end else if (fetch) begin
			pc <= pc + 32'd4;
		end
	end

	// fetch/decode valid bit.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idValid <= 1'b0;
		end else begin
			idValid <= fetch;
		end
	end

	// fetch/decode payload.
	always_ff @(posedge clk) begin
		if (fetch) begin
			idPc <= pc;
			idInstr <= instr;
			idRs <= rsData;
			idRt <= rtData;
		end
	end

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`default_nettype none

module decodeStage
	import pipePkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        flush,
	input  logic        idValid,
	input  logic [31:0] idPc,
	input  logic [31:0] idInstr,
	input  logic [31:0] idRs,
	input  logic [31:0] idRt,
	output logic        exValid,
	output logic [31:0] exPc,
	output logic [31:0] exA,
	output logic [31:0] exB,
	output logic [15:0] exImm,
	output logic [4:0]  exRd,
	output logic        exIsAdd,
	output logic        exTrap,
	output logic        exRd_en,
	output logic        exWr_en,
	output memSize_t    exSize,
	output excCode_t    exExc
);

	instrWord_t word;
	logic       isAdd;
	logic       isTrap;
	logic       isLoad;
	logic       isStore;
	memSize_t   size;
	excCode_t   code;
	logic [4:0] dest;

	assign word = idInstr;

	always_comb begin
		isAdd = 1'b0;
		isTrap = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		size = sizeWord;
		code = excNone;
		dest = word.iType.rt;
		case (word.iType.opcode)
			opSpecial: begin
				// register format, result goes to rd.
				dest = word.rType.rd;
				case (word.rType.funct)
					fnAdd: begin
						isAdd = 1'b1;
						isTrap = 1'b1;
					end
					fnAddu: isAdd = 1'b1;
					default: code = excRI;
				endcase
			end
			opLw: isLoad = 1'b1;
			opLh: begin
				isLoad = 1'b1;
				size = sizeHalf;
			end
			opLhu: begin
				isLoad = 1'b1;
				size = sizeHalfU;
			end
			opSw: isStore = 1'b1;
			opSh: begin
				isStore = 1'b1;
				size = sizeHalf;
			end
			default: code = excRI;
		endcase
	end

	// decode/execute control, bubbles carry no controls.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			exValid <= 1'b0;
			exIsAdd <= 1'b0;
			exTrap <= 1'b0;
			exRd_en <= 1'b0;
			exWr_en <= 1'b0;
			exExc <= excNone;
		end else begin
			exValid <= idValid;
			exIsAdd <= idValid && isAdd;
			exTrap <= idValid && isTrap;
			exRd_en <= idValid && isLoad;
			exWr_en <= idValid && isStore;
			exExc <= idValid ? code : excNone;
		end
	end

	// decode/execute payload.
	always_ff @(posedge clk) begin
		exPc <= idPc;
		exA <= idRs;
		exB <= idRt;
		exImm <= word.iType.imm;
		exRd <= dest;
		exSize <= size;
	end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`default_nettype none

module executeStage
	import pipePkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        flush,
	input  logic        exValid,
	input  logic [31:0] exPc,
	input  logic [31:0] exA,
	input  logic [31:0] exB,
	input  logic [15:0] exImm,
	input  logic [4:0]  exRd,
	input  logic        exIsAdd,
	input  logic        exTrap,
	input  logic        exRd_en,
	input  logic        exWr_en,
	input  memSize_t    exSize,
	input  excCode_t    exExc,
	output logic        memAddWr,
	output logic        memRd,
	output logic        memWr,
	output memSize_t    memSize,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	output logic [31:0] memSum,
	output logic [4:0]  memWbRd,
	output logic        memExc,
	output excCode_t    memExcCode,
	output logic [31:0] memBadAddr,
	output logic [31:0] memPc
);

	logic [31:0] opB;
	logic [31:0] sum;
	logic        overflow;
	logic        misaligned;
	logic        excepting;
	excCode_t    code;
	logic [31:0] badAddr;

	// second operand is rt for adds, the sign-extended offset for memory ops.
	assign opB = exIsAdd ? exB : {{16{exImm[15]}}, exImm};
	assign sum = exA + opB;
	assign overflow = (exA[31] == opB[31]) && (sum[31] != exA[31]);

	// words need both low bits clear, halves only bit 0.
	assign misaligned = (exSize == sizeWord) ? (sum[1:0] != 2'b00) : sum[0];

	// oldest cause first.
	always_comb begin
		excepting = 1'b1;
		code = excNone;
		badAddr = exPc;
		if (exValid && exExc != excNone) begin
			code = exExc;
		end else if (exValid && exTrap && overflow) begin
			code = excOv;
		end else if (exWr_en && misaligned) begin
			code = excAdES;
			badAddr = sum;
		end else if (exRd_en && misaligned) begin
			code = excAdEL;
			badAddr = sum;
		end else begin
			excepting = 1'b0;
		end
	end

	// execute/memory control.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			memAddWr <= 1'b0;
			memRd <= 1'b0;
			memWr <= 1'b0;
			memExc <= 1'b0;
			memExcCode <= excNone;
		end else begin
			memAddWr <= exValid && exIsAdd && !excepting;
			memRd <= exRd_en && !excepting;
			memWr <= exWr_en && !excepting;
			memExc <= excepting;
			memExcCode <= code;
		end
	end

	// execute/memory payload.
	always_ff @(posedge clk) begin
		memSize <= exSize;
		memAddr <= sum;
		memWData <= exB;
		memWbRd <= exRd;
		memBadAddr <= badAddr;
		memPc <= exPc;
	end

	// the add result and the memory address are the same adder output.
	assign memSum = memAddr;

endmodule

`default_nettype wire

// File: hw/commitStage.sv
`default_nettype none

module commitStage
	import pipePkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        memAddWr,
	input  logic [31:0] memSum,
	input  logic [4:0]  memWbRd,
	input  logic        memExc,
	input  excCode_t    memExcCode,
	input  logic [31:0] memBadAddr,
	input  logic [31:0] memPc,
	output logic        flush,
	output logic        wbValid,
	output logic [4:0]  wbRd,
	output logic [31:0] wbData,
	output logic        excValid,
	output excCode_t    excCode,
	output logic [31:0] epc,
	output logic [31:0] badVAddr
);

	// everything younger than an excepting instruction is dropped.
	assign flush = memExc;

	// single-cycle strobes.
	always_ff @(posedge clk) begin
		if (!rst) begin
			wbValid <= 1'b0;
			excValid <= 1'b0;
		end else begin
			wbValid <= memAddWr;
			excValid <= memExc;
		end
	end

	// exception record, held until the next exception.
	always_ff @(posedge clk) begin
		if (!rst) begin
			excCode <= excNone;
			epc <= 32'd0;
			badVAddr <= 32'd0;
		end else if (memExc) begin
			excCode <= memExcCode;
			epc <= memPc;
			badVAddr <= memBadAddr;
		end
	end

	// memory/writeback payload.
	always_ff @(posedge clk) begin
		wbRd <= memWbRd;
		wbData <= memSum;
	end

endmodule

`default_nettype wire

// File: hw/exceptPipe.sv
`default_nettype none

module exceptPipe
	import pipePkg::*;
#(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_3000,
	parameter logic [31:0] EXC_VECTOR   = 32'h8000_0180
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        fetch,
	input  logic [31:0] instr,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic [31:0] pc,
	output logic        memRd,
	output logic        memWr,
	output memSize_t    memSize,
	output logic [31:0] memAddr,
	output logic [31:0] memWData,
	output logic        wbValid,
	output logic [4:0]  wbRd,
	output logic [31:0] wbData,
	output logic        excValid,
	output excCode_t    excCode,
	output logic [31:0] epc,
	output logic [31:0] badVAddr
);

	logic        flush;
	logic        idValid;
	logic [31:0] idPc;
	logic [31:0] idInstr;
	logic [31:0] idRs;
	logic [31:0] idRt;
	logic        exValid;
	logic [31:0] exPc;
	logic [31:0] exA;
	logic [31:0] exB;
	logic [15:0] exImm;
	logic [4:0]  exRd;
	logic        exIsAdd;
	logic        exTrap;
	logic        exRd_en;
	logic        exWr_en;
	memSize_t    exSize;
	excCode_t    exExc;
	logic        memAddWr;
	logic [31:0] memSum;
	logic [4:0]  memWbRd;
	logic        memExc;
	excCode_t    memExcCode;
	logic [31:0] memBadAddr;
	logic [31:0] memPc;

	fetchStage #(
		.RESET_VECTOR(RESET_VECTOR),
		.EXC_VECTOR(EXC_VECTOR)
	) fetchStage_inst (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.flush(flush),
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.pc(pc),
		.idValid(idValid),
		.idPc(idPc),
		.idInstr(idInstr),
		.idRs(idRs),
		.idRt(idRt)
	);

	decodeStage decodeStage_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.idValid(idValid),
		.idPc(idPc),
		.idInstr(idInstr),
		.idRs(idRs),
		.idRt(idRt),
		.exValid(exValid),
		.exPc(exPc),
		.exA(exA),
		.exB(exB),
		.exImm(exImm),
		.exRd(exRd),
		.exIsAdd(exIsAdd),
		.exTrap(exTrap),
		.exRd_en(exRd_en),
		.exWr_en(exWr_en),
		.exSize(exSize),
		.exExc(exExc)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.exValid(exValid),
		.exPc(exPc),
		.exA(exA),
		.exB(exB),
		.exImm(exImm),
		.exRd(exRd),
		.exIsAdd(exIsAdd),
		.exTrap(exTrap),
		.exRd_en(exRd_en),
		.exWr_en(exWr_en),
		.exSize(exSize),
		.exExc(exExc),
		.memAddWr(memAddWr),
		.memRd(memRd),
		.memWr(memWr),
		.memSize(memSize),
		.memAddr(memAddr),
		.memWData(memWData),
		.memSum(memSum),
		.memWbRd(memWbRd),
		.memExc(memExc),
		.memExcCode(memExcCode),
		.memBadAddr(memBadAddr),
		.memPc(memPc)
	);

	commitStage commitStage_inst (
		.clk(clk),
		.rst(rst),
		.memAddWr(memAddWr),
		.memSum(memSum),
		.memWbRd(memWbRd),
		.memExc(memExc),
		.memExcCode(memExcCode),
		.memBadAddr(memBadAddr),
		.memPc(memPc),
		.flush(flush),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.excValid(excValid),
		.excCode(excCode),
		.epc(epc),
		.badVAddr(badVAddr)
	);

endmodule

`default_nettype wire

// File: verif/clockGen.sv
`default_nettype none

module clockGen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset is released on a rising edge, like any other stimulus.
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/exceptPipe_props.sv
`default_nettype none

module exceptPipe_props (
	input logic clk,
	input logic rst,
	input logic memRd,
	input logic memWr,
	input logic wbValid,
	input logic excValid
);

	// failing assertions are counted here as well.
	int unsigned failCount = 0;

	// one access is either a read or a write.
	assert property (@(posedge clk) disable iff (!rst) !(memRd && memWr))
	else begin
		failCount++;
		$error("memRd and memWr are both high");
	end

	// an excepting instruction never writes back.
	assert property (@(posedge clk) disable iff (!rst) excValid |-> !wbValid)
	else begin
		failCount++;
		$error("wbValid is high together with excValid");
	end

	// the flush has already emptied the memory stage.
	assert property (@(posedge clk) disable iff (!rst) $rose(excValid) |-> !memRd && !memWr)
	else begin
		failCount++;
		$error("memory request is active while excValid rises");
	end

endmodule

bind exceptPipe exceptPipe_props exceptPipe_props_inst (
	.clk(clk),
	.rst(rst),
	.memRd(memRd),
	.memWr(memWr),
	.wbValid(wbValid),
	.excValid(excValid)
);

`default_nettype wire

// File: verif/exceptPipeTb.sv
`default_nettype none

module exceptPipeTb
	import pipePkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam logic [31:0] RESET_VECTOR = 32'h0000_3000;
	localparam logic [31:0] EXC_VECTOR = 32'h8000_0180;
	localparam int RANDOM_SLOTS = 400;
	localparam int DIRECTED_SLOTS = 24;
	localparam int DRAIN_SLOTS = 6;
	localparam int MAX_CYCLES = 1024;
	localparam int TIMEOUT = (RANDOM_SLOTS + DIRECTED_SLOTS + DRAIN_SLOTS + 20) * CLK_PERIOD;

	// what the DUT outputs should show in one cycle.
	typedef struct packed {
		logic        chkPc;
		logic [31:0] pc;
		logic        rd;
		logic        wr;
		memSize_t    size;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        wb;
		logic [4:0]  wbRd;
		logic [31:0] wbData;
		logic        exc;
		excCode_t    code;
		logic [31:0] epc;
		logic [31:0] bad;
	} cycleExp_t;

	logic        clk;
	logic        rst;
	logic        fetch;
	logic [31:0] instr;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] pc;
	logic        memRd;
	logic        memWr;
	memSize_t    memSize;
	logic [31:0] memAddr;
	logic [31:0] memWData;
	logic        wbValid;
	logic [4:0]  wbRd;
	logic [31:0] wbData;
	logic        excValid;
	excCode_t    excCode;
	logic [31:0] epc;
	logic [31:0] badVAddr;

	cycleExp_t   expAt [MAX_CYCLES];
	cycleExp_t   now;
	int          cycle = 0;
	logic [15:0] lfsr;
	logic [31:0] modelPc;
	logic        lastFetch;
	int          flushEdge;
	int          wantWb;
	int          wantExc;
	int          wantMem;
	int          seenWb = 0;
	int          seenExc = 0;
	int          seenMem = 0;
	excCode_t    recCode = excNone;
	logic [31:0] recEpc = 32'd0;
	logic [31:0] recBad = 32'd0;

	clockGen #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(2)
	) clockGen_inst (
		.clk(clk),
		.rst(rst)
	);

	exceptPipe #(
		.RESET_VECTOR(RESET_VECTOR),
		.EXC_VECTOR(EXC_VECTOR)
	) exceptPipe_inst (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.pc(pc),
		.memRd(memRd),
		.memWr(memWr),
		.memSize(memSize),
		.memAddr(memAddr),
		.memWData(memWData),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.excValid(excValid),
		.excCode(excCode),
		.epc(epc),
		.badVAddr(badVAddr)
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic failRun();
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkCode(input string name, input excCode_t got, input excCode_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %s (%0d), expected %s (%0d)",
				$time, name, got.name(), got, exp.name(), exp);
			failRun();
		end
	endtask

	task automatic checkSize(input string name, input memSize_t got, input memSize_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %s (%0d), expected %s (%0d)",
				$time, name, got.name(), got, exp.name(), exp);
			failRun();
		end
	endtask

	// galois lfsr, taps 16, 14, 13, 11.
	function automatic logic nextBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 16'hb400;
		end
		return out;
	endfunction

	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], nextBit()};
		end
		return v;
	endfunction

	// outcome of one instruction on its own, from the ISA rules.
	function automatic cycleExp_t predict(input logic [31:0] word, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] at);
		cycleExp_t   r;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [32:0] wide;
		logic [31:0] ea;
		logic        isLoad;
		logic        isStore;
		logic        badAlign;
		memSize_t    sz;
		r = '0;
		r.code = excNone;
		r.epc = at;
		r.bad = at;
		op = word[31:26];
		fn = word[5:0];
		isLoad = (op == opLw) || (op == opLh) || (op == opLhu);
		isStore = (op == opSw) || (op == opSh);
		sz = (op == opLhu) ? sizeHalfU : ((op == opLh || op == opSh) ? sizeHalf : sizeWord);
		ea = a + {{16{word[15]}}, word[15:0]};
		badAlign = (sz == sizeWord) ? ((ea % 32'd4) != 0) : ((ea % 32'd2) != 0);
		if (op == opSpecial && (fn == fnAdd || fn == fnAddu)) begin
			wide = {a[31], a} + {b[31], b};
			if (fn == fnAdd && wide[32] != wide[31]) begin
				r.exc = 1'b1;
				r.code = excOv;
			end else begin
				r.wb = 1'b1;
				r.wbRd = word[15:11];
				r.wbData = wide[31:0];
			end
		end else if (isLoad || isStore) begin
			if (badAlign) begin
				r.exc = 1'b1;
				r.code = isStore ? excAdES : excAdEL;
				r.bad = ea;
			end else begin
				r.rd = isLoad;
				r.wr = isStore;
				r.size = sz;
				r.addr = ea;
				r.wdata = b;
			end
		end else begin
			r.exc = 1'b1;
			r.code = excRI;
		end
		return r;
	endfunction

	// one clock edge of stimulus, with the pipeline bookkeeping for it.
	task automatic advance(input logic doFetch, input logic [31:0] word,
			input logic [31:0] a, input logic [31:0] b);
		int        k;
		int        n;
		cycleExp_t r;
		@(posedge clk);
		k = cycle + 1;
		if (k == flushEdge) begin
			modelPc = EXC_VECTOR;
		end else if (lastFetch) begin
			modelPc = modelPc + 32'd4;
		end
		expAt[k].chkPc = 1'b1;
		expAt[k].pc = modelPc;
		fetch <= doFetch;
		instr <= word;
		rsData <= a;
		rtData <= b;
		lastFetch = doFetch;
		n = k + 1;
		// anything accepted up to the flush edge is dropped.
		if (doFetch && n > flushEdge) begin
			r = predict(word, a, b, modelPc);
			expAt[n + 2].rd = r.rd;
			expAt[n + 2].wr = r.wr;
			expAt[n + 2].size = r.size;
			expAt[n + 2].addr = r.addr;
			expAt[n + 2].wdata = r.wdata;
			expAt[n + 3].wb = r.wb;
			expAt[n + 3].wbRd = r.wbRd;
			expAt[n + 3].wbData = r.wbData;
			expAt[n + 3].exc = r.exc;
			expAt[n + 3].code = r.code;
			expAt[n + 3].epc = r.epc;
			expAt[n + 3].bad = r.bad;
			if (r.exc) begin
				flushEdge = n + 3;
				wantExc++;
			end
			if (r.wb) begin
				wantWb++;
			end
			if (r.rd || r.wr) begin
				wantMem++;
			end
		end
	endtask

	task automatic issue(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
		advance(1'b1, word, a, b);
	endtask

	task automatic idle();
		advance(1'b0, 32'd0, 32'd0, 32'd0);
	endtask

	task automatic randomSlot();
		logic [31:0] gap;
		logic [31:0] sel;
		logic [31:0] fields;
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] imm;
		logic [31:0] word;
		gap = drawBits(2);
		if (gap == 0) begin
			idle();
		end else begin
			sel = drawBits(6);
			fields = drawBits(31);
			a = drawBits(32);
			b = drawBits(32);
			imm = fields[15:0];
			// most memory ops are kept aligned.
			if (sel[4:3] != 2'b00) begin
				a[1:0] = 2'b00;
				imm[1:0] = 2'b00;
			end
			case (sel[2:0])
				3'd0: word = {opSpecial, fields[30:16], 5'd0, fnAdd};
				3'd1: word = {opSpecial, fields[30:16], 5'd0, fnAddu};
				3'd2: word = {opLw, fields[30:21], imm};
				3'd3: word = {opLh, fields[30:21], imm};
				3'd4: word = {opLhu, fields[30:21], imm};
				3'd5: word = {opSw, fields[30:21], imm};
				3'd6: word = {opSh, fields[30:21], imm};
				default: word = sel[5] ? {opSpecial, fields[30:16], 5'd0, 6'h22}
					: {6'h3f, fields[30:21], imm};
			endcase
			issue(word, a, b);
		end
	endtask

	// outputs are compared at the falling edge.
	always @(negedge clk) begin
		if (rst && cycle < MAX_CYCLES) begin
			now = expAt[cycle];
			if (now.chkPc) begin
				checkWord("pc", pc, now.pc);
			end
			checkBit("memRd", memRd, now.rd);
			checkBit("memWr", memWr, now.wr);
			if (memRd || memWr) begin
				seenMem++;
			end
			if (now.rd || now.wr) begin
				checkSize("memSize", memSize, now.size);
				checkWord("memAddr", memAddr, now.addr);
			end
			if (now.wr) begin
				checkWord("memWData", memWData, now.wdata);
			end
			checkBit("wbValid", wbValid, now.wb);
			if (wbValid) begin
				seenWb++;
			end
			if (now.wb) begin
				checkWord("wbRd", {27'd0, wbRd}, {27'd0, now.wbRd});
				checkWord("wbData", wbData, now.wbData);
			end
			checkBit("excValid", excValid, now.exc);
			if (excValid) begin
				seenExc++;
			end
			if (now.exc) begin
				recCode = now.code;
				recEpc = now.epc;
				recBad = now.bad;
			end
			checkCode("excCode", excCode, recCode);
			checkWord("epc", epc, recEpc);
			checkWord("badVAddr", badVAddr, recBad);
		end
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired before the stimulus finished");
		failRun();
	end

	initial begin
		fetch = 1'b0;
		instr = 32'd0;
		rsData = 32'd0;
		rtData = 32'd0;
		lfsr = 16'd25881;
		modelPc = RESET_VECTOR;
		lastFetch = 1'b0;
		flushEdge = 0;
		wantWb = 0;
		wantExc = 0;
		wantMem = 0;
		for (int i = 0; i < MAX_CYCLES; i++) begin
			expAt[i] = '0;
		end
		@(posedge clk);
		issue({opSpecial, 5'd1, 5'd2, 5'd3, 5'd0, fnAddu}, 32'hffff_ffff, 32'd2);
		issue({opSpecial, 5'd1, 5'd2, 5'd4, 5'd0, fnAdd}, 32'd5, 32'd7);
		idle();
		issue({opLw, 5'd1, 5'd5, 16'h0008}, 32'h0000_1000, 32'd0);
		issue({opSh, 5'd1, 5'd6, 16'hfffe}, 32'h0000_2004, 32'habcd_1234);
		issue({opLhu, 5'd1, 5'd7, 16'h0002}, 32'h0000_3000, 32'd0);
		// overflow, three younger adds are dropped and the fourth runs at the vector.
		issue({opSpecial, 5'd1, 5'd2, 5'd8, 5'd0, fnAdd}, 32'h7fff_ffff, 32'd1);
		repeat (4) issue({opSpecial, 5'd1, 5'd2, 5'd9, 5'd0, fnAddu}, 32'd1, 32'd1);
		issue({opLh, 5'd1, 5'd7, 16'h0001}, 32'h0000_1000, 32'd0);
		repeat (3) idle();
		issue({opSw, 5'd1, 5'd7, 16'h0000}, 32'h0000_1002, 32'h1234_5678);
		repeat (3) idle();
		issue(32'hfc00_0000, 32'd0, 32'd0);
		repeat (3) idle();
		repeat (RANDOM_SLOTS) randomSlot();
		repeat (DRAIN_SLOTS) idle();
		if (seenWb == wantWb && seenExc == wantExc && seenMem == wantMem
				&& wantWb > 0 && wantExc > 0 && wantMem > 0
				&& exceptPipe_inst.exceptPipe_props_inst.failCount == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("result counts or assertions do not match: wb %0d/%0d exc %0d/%0d mem %0d/%0d",
				seenWb, wantWb, seenExc, wantExc, seenMem, wantMem);
			failRun();
		end
	end

endmodule

`default_nettype wire

// File: sim.f
hw/pipePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/commitStage.sv
hw/exceptPipe.sv
verif/clockGen.sv
verif/exceptPipe_props.sv
verif/exceptPipeTb.sv

// File: Bender.yml
package:
  name: except_pipe

sources:
  - files:
      - hw/pipePkg.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/commitStage.sv
      - hw/exceptPipe.sv
  - target: simulation
    files:
      - verif/clockGen.sv
      - verif/exceptPipe_props.sv
      - verif/exceptPipeTb.sv
